//--- Makefile
TOP = baby_vga_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- filelist.f
hdl/baby_vga_pkg.sv
hdl/bus_port.sv
hdl/frame_store.sv
hdl/vga_timing.sv
hdl/pixel_out.sv
hdl/baby_vga.sv
verif/tb_clock.sv
verif/baby_vga_tb.sv

//--- hdl/baby_vga.sv
// Top level: bus port, frame store, raster timer and pixel output stage wired together.
module baby_vga #(
    parameter int col_clks  = baby_vga_pkg::def_col_clks,   // Clocks per cell column.
    parameter int row_lines = baby_vga_pkg::def_row_lines,  // Lines per cell row.
    parameter int h_front   = baby_vga_pkg::def_h_front,    // Horizontal front porch, clocks.
    parameter int h_sync    = baby_vga_pkg::def_h_sync,     // Horizontal sync width, clocks.
    parameter int h_back    = baby_vga_pkg::def_h_back,     // Horizontal back porch, clocks.
    parameter int v_front   = baby_vga_pkg::def_v_front,    // Vertical front porch, lines.
    parameter int v_sync    = baby_vga_pkg::def_v_sync,     // Vertical sync width, lines.
    parameter int v_back    = baby_vga_pkg::def_v_back      // Vertical back porch, lines.
) (
    input  logic                  clk,
    input  logic                  rst_n,         // Synchronous, active low.
    input  logic [5:0]            address,       // Bits 5:2 pick the row.
    input  logic [31:0]           data_in,       // Write data, whole word only.
    input  baby_vga_pkg::access_t data_write_n,  // Write size code.
    input  baby_vga_pkg::access_t data_read_n,   // Read size code.
    output baby_vga_pkg::row_t    data_out,      // Read data, valid with data_ready.
    output logic                  data_ready,    // One-cycle read completion pulse.
    output logic [7:0]            uo_out         // {hsync, pix x3, vsync, pix x3}.
);

    // Bus side to frame store.
    logic                     wr_en;
    baby_vga_pkg::row_addr_t  wr_row;
    baby_vga_pkg::row_t       wr_data;
    logic                     rd_en;
    baby_vga_pkg::row_addr_t  rd_row;
    baby_vga_pkg::row_t       rd_data;

    // Raster position and display data.
    logic [4:0]               col;        // Cell column under the beam.
    baby_vga_pkg::row_addr_t  row;        // Cell row under the beam.
    logic                     hsync_l;    // Active-low horizontal sync level.
    logic                     vsync_l;    // Active-low vertical sync level.
    logic                     blank;      // High outside the visible area.
    baby_vga_pkg::row_t       disp_data;  // Row currently being scanned.

    bus_port bus_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .address    (address),
        .data_write_n(data_write_n),
        .data_read_n(data_read_n),
        .data_in    (data_in),
        .rd_data    (rd_data),
        .wr_en      (wr_en),
        .wr_row     (wr_row),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_row     (rd_row),
        .data_out   (data_out),
        .data_ready (data_ready)
    );

    frame_store store_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_row   (wr_row),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_row   (rd_row),
        .row      (row),
        .rd_data  (rd_data),
        .disp_data(disp_data)
    );

    vga_timing #(
        .col_clks     (col_clks),
        .row_lines    (row_lines),
        .h_front_clks (h_front),
        .h_sync_clks  (h_sync),
        .h_back_clks  (h_back),
        .v_front_lines(v_front),
        .v_sync_lines (v_sync),
        .v_back_lines (v_back)
    ) timing_i (
        .clk   (clk),
        .rst_n (rst_n),
        .col   (col),
        .row   (row),
        .h_sync(hsync_l),
        .v_sync(vsync_l),
        .blank (blank)
    );

    pixel_out pixel_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .col      (col),
        .disp_data(disp_data),
        .blank    (blank),
        .h_sync   (hsync_l),
        .v_sync   (vsync_l),
        .uo_out   (uo_out)
    );

endmodule

//--- hdl/baby_vga_pkg.sv
// Shared package: bus access-size codes, framebuffer row types, sizes and default raster timing.
package baby_vga_pkg;

    // Size codes on data_write_n and data_read_n, as the bus drives them.
    typedef enum logic [1:0] {
        acc_byte = 2'b00,  // 8-bit access, ignored by this peripheral.
        acc_half = 2'b01,  // 16-bit access, ignored as well.
        acc_word = 2'b10,  // 32-bit access, the only one that is served.
        acc_none = 2'b11   // Idle bus.
    } access_t;

    // Framebuffer geometry in cells.
    localparam int num_cols = 32;
    localparam int num_rows = 16;

    // One framebuffer row. Bit c is column c and column 0 is leftmost on screen.
    typedef logic [num_cols-1:0] row_t;

    // Row index, 0 to 15.
    typedef logic [$clog2(num_rows)-1:0] row_addr_t;

    // Default raster timing for a 1024x768 mode at one clock per screen pixel.
    // Each cell is 32 clocks wide and 48 lines tall, so 32 x 16 cells fill the screen.
    localparam int def_col_clks  = 32;   // Clocks per cell column.
    localparam int def_row_lines = 48;   // Lines per cell row.

    // Horizontal porches and sync, in clocks. 1024 + 24 + 136 + 160 = 1344 per line.
    localparam int def_h_front = 24;
    localparam int def_h_sync  = 136;
    localparam int def_h_back  = 160;

    // Vertical porches and sync, in lines. 768 + 3 + 6 + 29 = 806 per frame.
    localparam int def_v_front = 3;
    localparam int def_v_sync  = 6;
    localparam int def_v_back  = 29;

endpackage

//--- hdl/bus_port.sv
// Bus port: word write decode, word read sequencing, read data register and data_ready pulse.
module bus_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [5:0]              address,       // Bits 1:0 are byte lanes, not decoded.
    input  baby_vga_pkg::access_t   data_write_n,
    input  baby_vga_pkg::access_t   data_read_n,
    input  logic [31:0]             data_in,
    input  baby_vga_pkg::row_t      rd_data,       // Registered row from the frame store.
    output logic                    wr_en,         // Write strobe for this cycle's edge.
    output baby_vga_pkg::row_addr_t wr_row,
    output baby_vga_pkg::row_t      wr_data,
    output logic                    rd_en,         // Frame store loads rd_data on this.
    output baby_vga_pkg::row_addr_t rd_row,        // Row latched at the read strobe.
    output baby_vga_pkg::row_t      data_out,
    output logic                    data_ready
);

    logic rd_stage1;  // First busy cycle, the frame store is being read.
    logic rd_stage2;  // Second busy cycle, rd_data holds the row.
    logic rd_strobe;  // Accepted word read.

    // Word writes go straight through and land on the next edge.
    assign wr_en   = (data_write_n == baby_vga_pkg::acc_word);  // Byte and half are dropped.
    assign wr_row  = address[5:2];
    assign wr_data = data_in;

    // A read is only taken while both busy stages are clear.
    // Byte and halfword reads never start the sequence, so they never complete.
    assign rd_strobe = (data_read_n == baby_vga_pkg::acc_word) && !rd_stage1 && !rd_stage2;

    assign rd_en = rd_stage1;  // The row register was loaded one edge earlier.

    // Busy sequence and data_ready. A strobe seen at edge n gives data_ready in the
    // cycle that starts at edge n+2.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_stage1  <= 1'b0;
            rd_stage2  <= 1'b0;
            data_ready <= 1'b0;
        end else begin
            rd_stage1  <= rd_strobe;
            rd_stage2  <= rd_stage1;
            data_ready <= rd_stage2;  // High for the single cycle after stage two.
        end
    end

    // Row select is captured on the strobe so that the address may change afterward.
    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            rd_row <= address[5:2];
        end
    end

    // Reply register. It loads on the same edge that raises data_ready and then
    // holds the word until the next read completes.
    always_ff @(posedge clk) begin
        if (rd_stage2) begin
            data_out <= rd_data;
        end
    end

endmodule

//--- hdl/frame_store.sv
// Frame store: sixteen row registers with a write port, a registered bus read and a display read.
module frame_store (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,      // Write wr_data into wr_row at the edge.
    input  baby_vga_pkg::row_addr_t wr_row,
    input  baby_vga_pkg::row_t      wr_data,
    input  logic                    rd_en,      // Load rd_data from rd_row at the edge.
    input  baby_vga_pkg::row_addr_t rd_row,
    input  baby_vga_pkg::row_addr_t row,        // Row under the beam.
    output baby_vga_pkg::row_t      rd_data,
    output baby_vga_pkg::row_t      disp_data
);

    // The picture itself. It starts blank after reset.
    baby_vga_pkg::row_t mem [baby_vga_pkg::num_rows];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < baby_vga_pkg::num_rows; i++) begin
                mem[i] <= '0;  // Screen comes up dark.
            end
        end else if (wr_en) begin
            mem[wr_row] <= wr_data;
        end
    end

    // Bus read. A write one edge earlier is already visible here.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_row];
        end
    end

    // Display read is combinational; pixel_out registers the selected bit.
    assign disp_data = mem[row];

endmodule

//--- hdl/pixel_out.sv
// Pixel output stage: bit select, blanking and the registered output byte.
module pixel_out (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [4:0]         col,        // Column under the beam.
    input  baby_vga_pkg::row_t disp_data,  // Row under the beam.
    input  logic               blank,
    input  logic               h_sync,     // Active low, straight from the timer.
    input  logic               v_sync,     // Active low, straight from the timer.
    output logic [7:0]         uo_out
);

    logic pixel;  // Framebuffer bit at the beam, dark during blanking.

    // Monitors expect black in the porches, so the bit is forced low there.
    assign pixel = blank ? 1'b0 : disp_data[col];

    // One register stage for everything, so syncs and pixel stay aligned.
    // The grey level is the same bit copied onto all six colour lines.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            uo_out <= 8'b1000_1000;  // Syncs idle high, pixel dark.
        end else begin
            uo_out <= {h_sync, {3{pixel}}, v_sync, {3{pixel}}};
        end
    end

endmodule

//--- hdl/vga_timing.sv
// Raster timer: cell clock and column counters, line and row counters, syncs and blanking.
module vga_timing #(
    parameter int col_clks      = 32,   // Clocks per cell column.
    parameter int row_lines     = 48,   // Lines per cell row.
    parameter int h_front_clks  = 24,   // Horizontal front porch.
    parameter int h_sync_clks   = 136,  // Horizontal sync pulse.
    parameter int h_back_clks   = 160,  // Horizontal back porch.
    parameter int v_front_lines = 3,    // Vertical front porch.
    parameter int v_sync_lines  = 6,    // Vertical sync pulse.
    parameter int v_back_lines  = 29    // Vertical back porch.
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [4:0]              col,     // Cell column, meaningful while visible.
    output baby_vga_pkg::row_addr_t row,     // Cell row, meaningful while visible.
    output logic                    h_sync,  // Active low.
    output logic                    v_sync,  // Active low.
    output logic                    blank    // High in any porch or sync.
);

    // The blanking interval is treated as one extra "column" whose length is the
    // sum of the porches and sync, and likewise one extra "row" vertically.
    localparam int h_blank = h_front_clks + h_sync_clks + h_back_clks;
    localparam int v_blank = v_front_lines + v_sync_lines + v_back_lines;

    // Each counter must hold the longer of a cell and the blanking interval.
    localparam int h_max = (col_clks > h_blank) ? col_clks : h_blank;
    localparam int v_max = (row_lines > v_blank) ? row_lines : v_blank;
    localparam int h_w   = $clog2(h_max + 1);
    localparam int v_w   = $clog2(v_max + 1);

    localparam int cw = $clog2(baby_vga_pkg::num_cols + 1);  // Holds 0 to num_cols.
    localparam int rw = $clog2(baby_vga_pkg::num_rows + 1);  // Holds 0 to num_rows.

    logic [h_w-1:0] h_cnt;   // Clock within the cell, or within horizontal blanking.
    logic [cw-1:0]  col_q;   // Cell column; num_cols means horizontal blanking.
    logic [v_w-1:0] v_cnt;   // Line within the cell row, or within vertical blanking.
    logic [rw-1:0]  row_q;   // Cell row; num_rows means vertical blanking.

    logic h_in_blank;  // Beam is right of the picture.
    logic v_in_blank;  // Beam is below the picture.
    logic h_end;       // Last clock of the current cell or of the blanking part.
    logic line_end;    // Last clock of the whole line.
    logic v_end;       // Last line of the current cell row or of vertical blanking.
    logic frame_end;   // Last line of the frame.

    assign h_in_blank = (col_q == cw'(baby_vga_pkg::num_cols));
    assign v_in_blank = (row_q == rw'(baby_vga_pkg::num_rows));

    assign h_end     = h_in_blank ? (h_cnt == h_w'(h_blank - 1))
                                  : (h_cnt == h_w'(col_clks - 1));
    assign line_end  = h_end && h_in_blank;
    assign v_end     = v_in_blank ? (v_cnt == v_w'(v_blank - 1))
                                  : (v_cnt == v_w'(row_lines - 1));
    assign frame_end = v_end && v_in_blank;

    // Horizontal pair. The column steps on every cell end and wraps after blanking.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            col_q <= '0;  // Start of the first visible line.
        end else if (h_end) begin
            h_cnt <= '0;
            col_q <= line_end ? '0 : col_q + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Vertical pair, stepped once per line.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v_cnt <= '0;
            row_q <= '0;
        end else if (line_end) begin
            if (v_end) begin
                v_cnt <= '0;
                row_q <= frame_end ? '0 : row_q + 1'b1;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    // Syncs sit after the front porch inside the blanking interval.
    assign h_sync = !(h_in_blank && (h_cnt >= h_w'(h_front_clks))
                      && (h_cnt < h_w'(h_front_clks + h_sync_clks)));
    assign v_sync = !(v_in_blank && (v_cnt >= v_w'(v_front_lines))
                      && (v_cnt < v_w'(v_front_lines + v_sync_lines)));

    assign blank = h_in_blank || v_in_blank;

    // Only the visible range is handed on; blanking is signalled separately.
    assign col = col_q[4:0];
    assign row = row_q[3:0];

endmodule

//--- verif/baby_vga_golden.txt
# Columns: kind, test name, byte address, write data, expected value (hex fields).
# For pix the address is the cell row and the data the cell column; 10 and 20 are blanking.
rst    reset_state          00 00000000 00000088
wr     write_row0           00 00000001 00000000
rd     read_row0            00 00000000 00000001
wr     write_row1           04 80000000 00000000
rd     read_row1            04 00000000 80000000
wr     write_row5           14 a5a5a5a5 00000000
rd     read_row5            14 00000000 a5a5a5a5
wr     write_row15          3c 0f0f00ff 00000000
rd     read_after_write     3c 00000000 0f0f00ff
wr     write_row7_lanes     1f 12345678 00000000
rd     read_row7            1c 00000000 12345678
wb     byte_write_row7      1c ffffffff 00000000
wh     half_write_row7      1c ffffffff 00000000
rd     read_row7_kept       1c 00000000 12345678
rdb    byte_read_ignored    1c 00000000 00000000
rdh    half_read_ignored    1c 00000000 00000000
rdbusy read_while_busy      14 00000000 a5a5a5a5
wr     write_row3           0c 00008001 00000000
wr     write_row3_again     0c c0000003 00000000
rd     read_row3            0c 00000000 c0000003
rd     read_row2_empty      08 00000000 00000000
sync   sync_frame           00 00000000 00000000
pix    pix_r0_c0            00 00000000 00000001
pix    pix_r0_c1            00 00000001 00000000
pix    pix_r1_c31           01 0000001f 00000001
pix    pix_r1_c30           01 0000001e 00000000
pix    pix_r3_c0            03 00000000 00000001
pix    pix_r3_c15           03 0000000f 00000000
pix    pix_r3_c31           03 0000001f 00000001
pix    pix_r5_c0            05 00000000 00000001
pix    pix_r5_c1            05 00000001 00000000
pix    pix_r5_c2            05 00000002 00000001
pix    pix_r15_c0           0f 00000000 00000001
pix    pix_r15_c8           0f 00000008 00000000
pix    pix_h_porch          05 00000020 00000000
pix    pix_v_porch          10 00000000 00000000
pix    pix_corner           10 00000020 00000000

//--- verif/baby_vga_tb.sv
// Testbench top with the golden file loader, bus driver tasks, raster model and result checks.
module baby_vga_tb;

    // Small raster so that a whole frame runs in a few thousand clocks.
    localparam int col_clks   = 4;
    localparam int row_lines  = 3;
    localparam int h_front    = 4;
    localparam int h_sync     = 8;
    localparam int h_back     = 4;
    localparam int v_front    = 1;
    localparam int v_sync     = 2;
    localparam int v_back     = 2;
    localparam int vis_clks   = baby_vga_pkg::num_cols * col_clks;     // 128 visible clocks.
    localparam int line_clks  = vis_clks + h_front + h_sync + h_back;  // 144 per line.
    localparam int vis_lines  = baby_vga_pkg::num_rows * row_lines;    // 48 visible lines.
    localparam int frame_clks = line_clks * (vis_lines + v_front + v_sync + v_back);

    logic                  clk;
    logic                  rst_n;
    logic [5:0]            address;
    logic [31:0]           data_in;
    baby_vga_pkg::access_t data_write_n;
    baby_vga_pkg::access_t data_read_n;
    baby_vga_pkg::row_t    data_out;
    logic                  data_ready;
    logic [7:0]            uo_out;

    // Golden operations with one entry per data line of the file.
    string       op_kind [$];
    string       op_name [$];
    logic [31:0] op_addr [$];
    logic [31:0] op_data [$];
    logic [31:0] op_exp  [$];

    baby_vga_pkg::row_t model [baby_vga_pkg::num_rows];  // Rows as the bus left them.
    int pos        = 0;   // Raster position the DUT counters hold now.
    int shown      = -1;  // Position that uo_out shows; -1 while it holds the reset value.
    int cycles     = 0;
    int limit      = 0;   // Timeout limit that is known once the golden file is loaded.
    int fail_count = 0;
    int test_count = 0;
    int pass_count = 0;
    bit test_ok;

    tb_clock #(.period(100), .reset_cycles(4)) clock_i (.clk(clk), .rst_n(rst_n));

    baby_vga #(.col_clks(col_clks), .row_lines(row_lines), .h_front(h_front), .h_sync(h_sync),
               .h_back(h_back), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)) dut_i (.*);

    // The output register shows, after each edge, where the counters stood before it.
    always @(posedge clk) begin
        if (!rst_n) begin
            pos   <= 0;
            shown <= -1;
        end else begin
            shown <= pos;
            pos   <= (pos + 1) % frame_clks;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: the tests did not finish within %0d clock cycles.", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_row(string name, baby_vga_pkg::row_t exp, baby_vga_pkg::row_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            fail_count++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            fail_count++;
            test_ok = 1'b0;
        end
    endtask

    // The sync pair is {hsync, vsync} and both are active low.
    task automatic check_sync(string name, logic [1:0] exp, logic [1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected syncs %b actual %b at position %0d", name, exp, act,
                     shown);
            fail_count++;
            test_ok = 1'b0;
        end
    endtask

    task automatic expect_colour(string name, logic want);
        check_bit(name, want, uo_out[6]);  // All six grey lines carry the same bit.
        check_bit(name, want, uo_out[5]);
        check_bit(name, want, uo_out[4]);
        check_bit(name, want, uo_out[2]);
        check_bit(name, want, uo_out[1]);
        check_bit(name, want, uo_out[0]);
    endtask

    // hsync is low in the sync part of each line, vsync in the sync lines.
    function automatic logic [1:0] predict_sync(int p);
        int x;
        int line;
        x    = p % line_clks;
        line = p / line_clks;
        return {!(x >= vis_clks + h_front && x < vis_clks + h_front + h_sync),
                !(line >= vis_lines + v_front && line < vis_lines + v_front + v_sync)};
    endfunction

    function automatic logic predict_pixel(logic [31:0] r, logic [31:0] c);
        if (r < baby_vga_pkg::num_rows && c < baby_vga_pkg::num_cols) begin
            return model[r[3:0]][c[4:0]];
        end
        return 1'b0;  // Porches and sync are dark.
    endfunction

    task automatic load_golden(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       kind;
        string       name;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("verif/baby_vga_golden.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h", kind, name, a, d, e);
                    if (n == 5) begin
                        op_kind.push_back(kind);
                        op_name.push_back(name);
                        op_addr.push_back(a);
                        op_data.push_back(d);
                        op_exp.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Clock edges each operation may take at most.
    function automatic int op_cost(string kind);
        case (kind)
            "rst":            return 6;
            "sync", "pix":    return frame_clks + 2;
            "wr", "wb", "wh": return 1;
            default:          return 7;
        endcase
    endfunction

    task automatic bus_idle();
        @(posedge clk);
        data_write_n <= baby_vga_pkg::acc_none;
        data_read_n  <= baby_vga_pkg::acc_none;
    endtask

    // The strobe stays up until the next operation drives the bus.
    task automatic bus_write(baby_vga_pkg::access_t size, logic [5:0] addr, logic [31:0] data);
        @(posedge clk);
        address      <= addr;
        data_in      <= data;
        data_write_n <= size;
        data_read_n  <= baby_vga_pkg::acc_none;
        if (size == baby_vga_pkg::acc_word) model[addr[5:2]] = data;
    endtask

    // Edge k = 0 is the strobe edge; data_ready belongs in the cycle after edge 2.
    // With hold set the strobe stays up through both busy cycles.
    task automatic bus_read(string name, logic [5:0] addr, baby_vga_pkg::access_t size,
                            bit hold, baby_vga_pkg::row_t exp);
        logic ready_due;
        @(posedge clk);
        address      <= addr;
        data_read_n  <= size;
        data_write_n <= baby_vga_pkg::acc_none;
        for (int k = 0; k < 5; k++) begin
            @(posedge clk);
            if ((k == 0 && !hold) || k == 2) data_read_n <= baby_vga_pkg::acc_none;
            @(negedge clk);
            ready_due = (size == baby_vga_pkg::acc_word) && (k == 2);
            check_bit(name, ready_due, data_ready);
            if (size == baby_vga_pkg::acc_word && k >= 2) check_row(name, exp, data_out);
        end
    endtask

    task automatic reset_state(string name, logic [7:0] exp);
        @(posedge clk);  // The first edge loads the reset value into the output register.
        do begin
            @(negedge clk);
            check_sync(name, {exp[7], exp[3]}, {uo_out[7], uo_out[3]});
            expect_colour(name, exp[0]);
            check_bit(name, 1'b0, data_ready);
        end while (!rst_n);  // The last pass is the first cycle out of reset.
    endtask

    task automatic sync_frame(string name);
        bus_idle();
        for (int i = 0; i < frame_clks; i++) begin
            @(negedge clk);
            check_sync(name, predict_sync(shown), {uo_out[7], uo_out[3]});
            if (!test_ok) break;
        end
    endtask

    // Samples land one line into the cell row and two clocks into the cell column.
    task automatic pixel_sample(string name, logic [31:0] r, logic [31:0] c, logic golden);
        int   target;
        logic want;
        bus_idle();
        target = (int'(r) * row_lines + 1) * line_clks + int'(c) * col_clks + 2;
        want   = predict_pixel(r, c);
        if (golden !== want) begin
            $display("Golden entry %s gives pixel %b but the written rows give %b.", name,
                     golden, want);
            fail_count++;
            test_ok = 1'b0;
        end
        do @(negedge clk); while (shown != target);
        expect_colour(name, want);
    endtask

    task automatic run_op(int i);
        string name;
        string kind;
        name    = op_name[i];
        kind    = op_kind[i];
        test_ok = 1'b1;
        case (kind)
            "rst":    reset_state(name, op_exp[i][7:0]);
            "wr":     bus_write(baby_vga_pkg::acc_word, op_addr[i][5:0], op_data[i]);
            "wb":     bus_write(baby_vga_pkg::acc_byte, op_addr[i][5:0], op_data[i]);
            "wh":     bus_write(baby_vga_pkg::acc_half, op_addr[i][5:0], op_data[i]);
            "rd":     bus_read(name, op_addr[i][5:0], baby_vga_pkg::acc_word, 1'b0, op_exp[i]);
            "rdbusy": bus_read(name, op_addr[i][5:0], baby_vga_pkg::acc_word, 1'b1, op_exp[i]);
            "rdb":    bus_read(name, op_addr[i][5:0], baby_vga_pkg::acc_byte, 1'b0, op_exp[i]);
            "rdh":    bus_read(name, op_addr[i][5:0], baby_vga_pkg::acc_half, 1'b0, op_exp[i]);
            "sync":   sync_frame(name);
            "pix":    pixel_sample(name, op_addr[i], op_data[i], op_exp[i][0]);
            default: begin
                $display("Unknown operation kind %s in the golden file.", kind);
                fail_count++;
                test_ok = 1'b0;
            end
        endcase
        if (!(kind == "wr" || kind == "wb" || kind == "wh")) begin  // A write only prepares rows.
            test_count++;
            if (test_ok) pass_count++;
            $display("%-24s %s", name, test_ok ? "passed" : "failed");
        end
    endtask

    initial begin
        bit loaded;
        int budget;
        address      <= '0;
        data_in      <= '0;
        data_write_n <= baby_vga_pkg::acc_none;
        data_read_n  <= baby_vga_pkg::acc_none;
        foreach (model[i]) model[i] = '0;  // The frame store clears on reset.
        load_golden(loaded);
        if (!loaded) begin
            $display("Cannot open verif/baby_vga_golden.txt for reading.");
            $display("Simulation failed");
            $finish;
        end else begin
            budget = 0;
            foreach (op_kind[i]) budget += op_cost(op_kind[i]);
            limit = 2 * budget + 2 * frame_clks;
            foreach (op_kind[i]) run_op(i);
            bus_idle();
            $display("Tests %0d, passed %0d, failed %0d, failed checks %0d", test_count,
                     pass_count, test_count - pass_count, fail_count);
            if (fail_count == 0 && test_count > 0 && pass_count == test_count) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

//--- verif/tb_clock.sv
// Testbench clock and synchronous reset generator.
module tb_clock #(
    parameter int period       = 100,  // Clock period in time units.
    parameter int reset_cycles = 4     // Rising edges that see reset low.
) (
    output logic clk,
    output logic rst_n
);

    int edges = 0;  // Rising edges seen so far.

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // The count moves on the rising edge, so reset lifts just after the last reset edge.
    always @(posedge clk) begin
        edges <= edges + 1;
    end

    assign rst_n = (edges >= reset_cycles);  // Low for exactly reset_cycles edges.

endmodule
